// File: hdl/corePkg.sv
package corePkg;

	typedef logic [4:0] Opcode;
	typedef logic [3:0] RegIndex;

	localparam int InstrWidth = 32;

	// Register-register forms
	localparam Opcode OpAdd = 5'd3;
	localparam Opcode OpSub = 5'd4;
	localparam Opcode OpAnd = 5'd5;
	localparam Opcode OpOr = 5'd6;

	// Immediate forms take C as the second operand
	localparam Opcode OpAddi = 5'd12;
	localparam Opcode OpAndi = 5'd13;
	localparam Opcode OpOri = 5'd14;

	// Bit positions inside the instruction word
	localparam int OpcodeMsb = 31;
	localparam int OpcodeLsb = 27;
	localparam int RaMsb = 26;
	localparam int RaLsb = 23;
	localparam int RbMsb = 22;
	localparam int RbLsb = 19;
	localparam int RcMsb = 18;
	localparam int RcLsb = 15;
	localparam int ImmMsb = 18;
	localparam int ImmLsb = 0;
	localparam int ImmWidth = ImmMsb - ImmLsb + 1;

	function automatic logic isKnownOpcode(input Opcode op);
		return op inside {OpAdd, OpSub, OpAnd, OpOr, OpAddi, OpAndi, OpOri};
	endfunction

	function automatic logic isImmediate(input Opcode op);
		return op inside {OpAddi, OpAndi, OpOri};
	endfunction

endpackage

// File: hdl/decodeStage.sv
module decodeStage #(
	parameter int DataWidth = 32
) (
	input  logic                             Clock,
	input  logic                             rst,
	input  logic                             instrValid,
	input  logic [corePkg::InstrWidth-1:0]   instr,
	output logic                             decValid,
	output corePkg::Opcode                   decOpcode,
	output corePkg::RegIndex                 decRa,
	output corePkg::RegIndex                 decRb,
	output corePkg::RegIndex                 decRc,
	output logic [DataWidth-1:0]             decImm
);
	import corePkg::*;

	logic [InstrWidth-1:0] instrReg;
	logic signed [ImmWidth-1:0] rawImm;

	// Words with an opcode outside the supported set never become valid
	always_ff @(posedge Clock) begin
		if (rst) begin
			decValid <= 1'b0;
		end else begin
			decValid <= instrValid && isKnownOpcode(instr[OpcodeMsb:OpcodeLsb]);
		end
	end

	always_ff @(posedge Clock) begin
		if (instrValid) begin
			instrReg <= instr;
		end
	end

	assign decOpcode = instrReg[OpcodeMsb:OpcodeLsb];
	assign decRa = instrReg[RaMsb:RaLsb];
	assign decRb = instrReg[RbMsb:RbLsb];
	assign decRc = instrReg[RcMsb:RcLsb];

	// C overlaps the Rc field; the consumer decides which one applies
	assign rawImm = instrReg[ImmMsb:ImmLsb];

	// Signed size cast extends or truncates to the datapath width
	assign decImm = DataWidth'(rawImm);

endmodule

// File: hdl/registerFile.sv
module registerFile #(
	parameter int DataWidth = 32
) (
	input  logic                   Clock,
	input  logic                   writeEnable,
	input  corePkg::RegIndex       writeReg,
	input  logic [DataWidth-1:0]   writeData,
	input  corePkg::RegIndex       readRegA,
	input  corePkg::RegIndex       readRegB,
	output logic [DataWidth-1:0]   readDataA,
	output logic [DataWidth-1:0]   readDataB
);
	import corePkg::*;

	localparam int NumRegs = 1 << $bits(RegIndex);

	logic [DataWidth-1:0] regs [NumRegs];

	always_ff @(posedge Clock) begin
		if (writeEnable) begin
			regs[writeReg] <= writeData;
		end
	end

	// A write in the same cycle is not visible here
	// The operand stage covers that case through its bypass
	assign readDataA = regs[readRegA];
	assign readDataB = regs[readRegB];

endmodule

// File: hdl/operandStage.sv
module operandStage #(
	parameter int DataWidth = 32
) (
	input  logic                   Clock,
	input  logic                   rst,
	input  logic                   decValid,
	input  corePkg::Opcode         decOpcode,
	input  corePkg::RegIndex       decRa,
	input  corePkg::RegIndex       decRb,
	input  corePkg::RegIndex       decRc,
	input  logic [DataWidth-1:0]   decImm,
	output corePkg::RegIndex       readRegA,
	output corePkg::RegIndex       readRegB,
	input  logic [DataWidth-1:0]   readDataA,
	input  logic [DataWidth-1:0]   readDataB,
	input  logic                   wbValid,
	input  corePkg::RegIndex       wbReg,
	input  logic [DataWidth-1:0]   wbData,
	output logic                   opValid,
	output corePkg::Opcode         opOpcode,
	output corePkg::RegIndex       opRa,
	output corePkg::RegIndex       opRb,
	output corePkg::RegIndex       opRc,
	output logic [DataWidth-1:0]   operandA,
	output logic [DataWidth-1:0]   operandB
);
	import corePkg::*;

	logic [DataWidth-1:0] valueA;
	logic [DataWidth-1:0] valueB;
	logic bypassA;
	logic bypassB;

	assign readRegA = decRb;
	assign readRegB = decRc;

	// The writeback in flight lands in the register file at the same edge
	// that captures the operands, so take it straight from the port
	assign bypassA = wbValid && (wbReg == decRb);
	assign bypassB = wbValid && (wbReg == decRc);

	assign valueA = bypassA ? wbData : readDataA;
	assign valueB = bypassB ? wbData : readDataB;

	always_ff @(posedge Clock) begin
		if (rst) begin
			opValid <= 1'b0;
		end else begin
			opValid <= decValid;
		end
	end

	always_ff @(posedge Clock) begin
		if (decValid) begin
			opOpcode <= decOpcode;
			opRa <= decRa;
			opRb <= decRb;
			opRc <= decRc;
			operandA <= valueA;
			operandB <= isImmediate(decOpcode) ? decImm : valueB;
		end
	end

endmodule

// File: hdl/aluStage.sv
module aluStage #(
	parameter int DataWidth = 32
) (
	input  logic                   Clock,
	input  logic                   rst,
	input  logic                   opValid,
	input  corePkg::Opcode         opOpcode,
	input  corePkg::RegIndex       opRa,
	input  corePkg::RegIndex       opRb,
	input  corePkg::RegIndex       opRc,
	input  logic [DataWidth-1:0]   operandA,
	input  logic [DataWidth-1:0]   operandB,
	output logic                   wbValid,
	output corePkg::RegIndex       wbReg,
	output logic [DataWidth-1:0]   wbData
);
	import corePkg::*;

	logic forwardA;
	logic forwardB;
	logic [DataWidth-1:0] srcA;
	logic [DataWidth-1:0] srcB;
	logic [DataWidth-1:0] result;

	// The result register holds the instruction just ahead of this one
	// It is newer than anything the operand stage could have seen
	assign forwardA = wbValid && (wbReg == opRb);

	// For immediate forms the Rc bits are part of C and name no register
	assign forwardB = wbValid && !isImmediate(opOpcode) && (wbReg == opRc);

	assign srcA = forwardA ? wbData : operandA;
	assign srcB = forwardB ? wbData : operandB;

	always_comb begin
		case (opOpcode)
			OpAdd, OpAddi: begin
				result = srcA + srcB;
			end
			OpSub: begin
				result = srcA - srcB;
			end
			OpAnd, OpAndi: begin
				result = srcA & srcB;
			end
			OpOr, OpOri: begin
				result = srcA | srcB;
			end
			default: begin
				// Unknown opcodes were already dropped in decode
				result = '0;
			end
		endcase
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= opValid;
		end
	end

	always_ff @(posedge Clock) begin
		if (opValid) begin
			wbReg <= opRa;
			wbData <= result;
		end
	end

endmodule

// File: hdl/immediateCore.sv
module immediateCore #(
	parameter int DataWidth = 32
) (
	input  logic                             Clock,
	input  logic                             rst,
	input  logic                             instrValid,
	input  logic [corePkg::InstrWidth-1:0]   instr,
	output logic                             wbValid,
	output corePkg::RegIndex                 wbReg,
	output logic [DataWidth-1:0]             wbData
);
	import corePkg::*;

	logic decValid;
	Opcode decOpcode;
	RegIndex decRa;
	RegIndex decRb;
	RegIndex decRc;
	logic [DataWidth-1:0] decImm;

	RegIndex readRegA;
	RegIndex readRegB;
	logic [DataWidth-1:0] readDataA;
	logic [DataWidth-1:0] readDataB;

	logic opValid;
	Opcode opOpcode;
	RegIndex opRa;
	RegIndex opRb;
	RegIndex opRc;
	logic [DataWidth-1:0] operandA;
	logic [DataWidth-1:0] operandB;

	decodeStage #(.DataWidth(DataWidth)) decodeStage_i (
		.Clock      (Clock),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.decValid   (decValid),
		.decOpcode  (decOpcode),
		.decRa      (decRa),
		.decRb      (decRb),
		.decRc      (decRc),
		.decImm     (decImm)
	);

	operandStage #(.DataWidth(DataWidth)) operandStage_i (
		.Clock     (Clock),
		.rst       (rst),
		.decValid  (decValid),
		.decOpcode (decOpcode),
		.decRa     (decRa),
		.decRb     (decRb),
		.decRc     (decRc),
		.decImm    (decImm),
		.readRegA  (readRegA),
		.readRegB  (readRegB),
		.readDataA (readDataA),
		.readDataB (readDataB),
		.wbValid   (wbValid),
		.wbReg     (wbReg),
		.wbData    (wbData),
		.opValid   (opValid),
		.opOpcode  (opOpcode),
		.opRa      (opRa),
		.opRb      (opRb),
		.opRc      (opRc),
		.operandA  (operandA),
		.operandB  (operandB)
	);

	// The registered writeback doubles as the register file write port
	registerFile #(.DataWidth(DataWidth)) registerFile_i (
		.Clock       (Clock),
		.writeEnable (wbValid),
		.writeReg    (wbReg),
		.writeData   (wbData),
		.readRegA    (readRegA),
		.readRegB    (readRegB),
		.readDataA   (readDataA),
		.readDataB   (readDataB)
	);

	aluStage #(.DataWidth(DataWidth)) aluStage_i (
		.Clock    (Clock),
		.rst      (rst),
		.opValid  (opValid),
		.opOpcode (opOpcode),
		.opRa     (opRa),
		.opRb     (opRb),
		.opRc     (opRc),
		.operandA (operandA),
		.operandB (operandB),
		.wbValid  (wbValid),
		.wbReg    (wbReg),
		.wbData   (wbData)
	);

endmodule

// File: verification/coreChecks_assert.sv
module coreChecks_assert (
	input logic          Clock,
	input logic          rst,
	input logic          instrValid,
	input logic [31:0]   instr,
	input logic          wbValid,
	input logic [3:0]    wbReg
);
	int cycles = 0;
	int failures = 0;

	always @(posedge Clock) begin
		cycles <= cycles + 1;
	end

	resetClearsWb: assert property (@(posedge Clock) rst |=> !wbValid)
		else begin
			failures++;
			$error("wbValid high after a reset cycle");
		end

	// A word sampled three sample points back shows up now unless a reset intervened
	latencyMatches: assert property (@(posedge Clock)
		(cycles > 4 && !$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3)) |->
		wbValid == $past(instrValid &&
			(instr[31:27] inside {5'd3, 5'd4, 5'd5, 5'd6, 5'd12, 5'd13, 5'd14}), 3))
		else begin
			failures++;
			$error("wbValid does not follow the accepted word");
		end

	wbRegKnown: assert property (@(posedge Clock) wbValid |-> !$isunknown(wbReg))
		else begin
			failures++;
			$error("wbReg has unknown bits while wbValid is high");
		end

endmodule

// File: verification/immediateCoreTb.sv
module immediateCoreTb;
	import corePkg::*;

	localparam int DataWidth = 32;
	localparam int InstrCount = 32 + 200 + 15 + 20 + 80;
	localparam longint Timeout = (InstrCount + 50) * 100 * 2;

	logic Clock;
	logic rst;
	logic instrValid;
	logic [31:0] instr;
	logic wbValid;
	RegIndex wbReg;
	logic [DataWidth-1:0] wbData;

	logic [15:0] lfsr = 16'd19;
	logic [DataWidth-1:0] shadow [16];
	logic [DataWidth-1:0] committed [16];
	RegIndex expReg [$];
	logic [DataWidth-1:0] expData [$];
	int valueErrors = 0;
	int protocolErrors = 0;

	immediateCore #(.DataWidth(DataWidth)) immediateCore_i (
		.Clock      (Clock),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.wbValid    (wbValid),
		.wbReg      (wbReg),
		.wbData     (wbData)
	);

	bind immediateCore coreChecks_assert coreChecks_i (.*);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	// Taps 16, 14, 13, 11
	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] bits;
		logic fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic logic knownOp(input logic [4:0] op);
		case (op)
			5'd3, 5'd4, 5'd5, 5'd6, 5'd12, 5'd13, 5'd14: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [DataWidth-1:0] expectedResult(
			input logic [DataWidth-1:0] regs [16], input logic [31:0] word);
		logic [DataWidth-1:0] a;
		logic [DataWidth-1:0] b;
		logic [DataWidth-1:0] c;
		a = regs[word[22:19]];
		b = regs[word[18:15]];
		c = DataWidth'({{13{word[18]}}, word[18:0]});
		case (word[31:27])
			5'd3: return a + b;
			5'd4: return a - b;
			5'd5: return a & b;
			5'd6: return a | b;
			5'd12: return a + c;
			5'd13: return a & c;
			default: return a | c;
		endcase
	endfunction

	task automatic sendWord(input logic [31:0] word);
		@(negedge Clock);
		instrValid = 1'b1;
		instr = word;
		if (knownOp(word[31:27])) begin
			expReg.push_back(word[26:23]);
			expData.push_back(expectedResult(shadow, word));
			shadow[word[26:23]] = expData[$];
		end
	endtask

	task automatic idleCycle();
		@(negedge Clock);
		instrValid = 1'b0;
		instr = randomBits(32);
	endtask

	function automatic logic [31:0] randomWord();
		logic [4:0] ops [7];
		logic [4:0] op;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [18:0] imm;
		ops = '{OpAdd, OpSub, OpAnd, OpOr, OpAddi, OpAndi, OpOri};
		op = ops[randomBits(3) % 7];
		ra = 4'(randomBits(4));
		rb = 4'(randomBits(4));
		imm = 19'(randomBits(19));
		return {op, ra, rb, imm};
	endfunction

	task automatic randomStream(input int count);
		logic [31:0] word;
		for (int i = 0; i < count; i++) begin
			if (randomBits(3) == 0) begin
				idleCycle();
			end
			word = randomWord();
			// Now and then replace the opcode with one the core does not know
			if (randomBits(4) == 0) begin
				do word[31:27] = 5'(randomBits(5)); while (knownOp(word[31:27]));
			end
			sendWord(word);
		end
	endtask

	// Compare on the falling edge, where the writeback outputs are stable
	initial begin
		forever begin
			@(negedge Clock);
			if (wbValid) begin
				if (expReg.size() == 0) begin
					protocolErrors++;
					$display("At %0t a writeback appeared with no instruction pending", $time);
				end else begin
					if (wbReg !== expReg[0]) begin
						valueErrors++;
						$display("Error %0t wbReg expected %0d actual %0d",
							$time, expReg[0], wbReg);
					end
					if (wbData !== expData[0]) begin
						valueErrors++;
						$display("Error %0t wbData expected %h actual %h",
							$time, expData[0], wbData);
					end
					committed[expReg[0]] = expData[0];
					void'(expReg.pop_front());
					void'(expData.pop_front());
				end
			end
		end
	end

	initial begin
		#(Timeout);
		$display("Watchdog expired before the tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		for (int r = 0; r < 16; r++) begin
			shadow[r] = '0;
			committed[r] = '0;
		end
		repeat (8) @(negedge Clock);
		rst = 1'b0;

		// Clear each register, then load a random value through its own result
		for (int r = 0; r < 16; r++) begin
			sendWord({OpAndi, 4'(r), 4'(r), 19'd0});
			sendWord({OpAddi, 4'(r), 4'(r), 19'(randomBits(19))});
		end

		randomStream(200);

		// Dependence at distance 1, 2 and 3 on both sources
		for (int d = 1; d <= 3; d++) begin
			sendWord({OpAddi, 4'd1, 4'd2, 19'(randomBits(19))});
			for (int k = 1; k < d; k++) begin
				sendWord({OpOri, 4'(8 + k), 4'd9, 19'(randomBits(19))});
			end
			sendWord({OpAdd, 4'd3, 4'd1, 4'd1, 15'd0});
			sendWord({OpSub, 4'd4, 4'd3, 4'd1, 15'd0});
			sendWord({OpAnd, 4'd5, 4'd4, 4'd3, 15'd0});
		end

		randomStream(20);
		@(negedge Clock);
		rst = 1'b1;
		instrValid = 1'b0;
		// Everything still in the pipeline is dropped at this edge
		@(posedge Clock);
		expReg.delete();
		expData.delete();
		shadow = committed;
		repeat (3) @(negedge Clock);
		rst = 1'b0;
		repeat (6) idleCycle();

		randomStream(80);
		repeat (10) idleCycle();

		if (expReg.size() != 0) begin
			protocolErrors++;
			$display("%0d expected writebacks never arrived", expReg.size());
		end
		$display("%0d value errors, %0d protocol errors, %0d assertion failures",
			valueErrors, protocolErrors, immediateCore_i.coreChecks_i.failures);
		if (valueErrors == 0 && protocolErrors == 0
				&& immediateCore_i.coreChecks_i.failures == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: sources.f
hdl/corePkg.sv
hdl/decodeStage.sv
hdl/registerFile.sv
hdl/operandStage.sv
hdl/aluStage.sv
hdl/immediateCore.sv
verification/coreChecks_assert.sv
verification/immediateCoreTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wall -Wno-fatal \
	-f sources.f --top-module immediateCoreTb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
grep -q "TESTBENCH PASSED" sim.log
